// ==== include/imu_spi_defines.svh ====
`ifndef IMU_SPI_DEFINES_SVH
`define IMU_SPI_DEFINES_SVH

// --------------------------------------------------
// Packet layout
// --------------------------------------------------

// Number of bytes in one packet, header and flags included
`define IMU_PACKET_BYTES 16

// Marker sent as byte 0 so the MCU can find the packet start
`define IMU_HEADER_BYTE 8'hAA

// --------------------------------------------------
// Clock domain crossing
// --------------------------------------------------

// Flops in every pin and status synchronizer chain, at least 2
`define IMU_SYNC_STAGES 2

// Bit positions inside the flags byte (byte 15)
`define IMU_FLAG_QUAT 0
`define IMU_FLAG_GYRO 1
`define IMU_FLAG_INIT 2
`define IMU_FLAG_ERR 3

`endif

// ==== hdl/imu_spi_pkg.sv ====
package imu_spi_pkg;

    // --------------------------------------------------
    // Data widths
    // --------------------------------------------------

    // One sensor word as delivered by the IMU controller
    // Quaternion and gyroscope components share this format
    typedef logic signed [15:0] sample_t;

    // One byte as it travels on the SPI wire
    typedef logic [7:0] byte_t;

    // Index of the byte being loaded into the shifter
    // Five bits so that it can point past the last packet byte,
    // where every index reads as zero
    typedef logic [4:0] byte_idx_t;

    // Bit position inside the current byte, 0 is the MSB sent first
    typedef logic [2:0] bit_idx_t;

    // Status group: quat valid, gyro valid, initialized, error
    // Positions inside the vector come from the defines header
    typedef logic [3:0] flags_t;

    // --------------------------------------------------
    // Shifter FSM
    // --------------------------------------------------

    // st_idle             slave not selected, sdo released
    // st_wait_first_rise  header loaded, master has not sampled yet
    // st_shifting         one bit per sck fall, new byte every 8 bits
    // st_drain            packet exhausted, zeros go out
    typedef enum logic [1:0] {
        st_idle,
        st_wait_first_rise,
        st_shifting,
        st_drain
    } shift_state_t;

endpackage

// ==== hdl/spi_events_if.sv ====
`timescale 1ns/10ps

// Events seen on the SPI pins, already moved into the clk domain
interface spi_events_if;

    // High while the master holds ss_n low, after synchronization
    logic selected;

    // One clk cycle strobes for the slave select edges
    logic ss_fall;
    logic ss_rise;

    // One clk cycle strobes for sck edges, only while selected
    logic sck_rise;
    logic sck_fall;

    // The pin synchronizer owns every signal
    modport src (output selected, ss_fall, ss_rise, sck_rise, sck_fall);

    // Capture and shifter blocks only look at the events
    modport dst (input selected, ss_fall, ss_rise, sck_rise, sck_fall);

endinterface

// ==== hdl/sensor_snap_if.sv ====
`timescale 1ns/10ps

// Frozen copy of the sensor state that the packet is built from
interface sensor_snap_if;
    import imu_spi_pkg::*;

    // Quaternion components, last valid sample
    sample_t quat_w;
    sample_t quat_x;
    sample_t quat_y;
    sample_t quat_z;

    // Gyroscope components, last valid sample
    sample_t gyro_x;
    sample_t gyro_y;
    sample_t gyro_z;

    // Valid latches and status bits at the positions of the flags byte
    flags_t flags;

    // Written by the capture block
    modport src (output quat_w, quat_x, quat_y, quat_z,
                 output gyro_x, gyro_y, gyro_z, flags);

    // Read by the packet builder
    modport dst (input quat_w, quat_x, quat_y, quat_z,
                 input gyro_x, gyro_y, gyro_z, flags);

endinterface

// ==== hdl/spi_pin_sync.sv ====
`timescale 1ns/10ps
`include "imu_spi_defines.svh"

module spi_pin_sync (
    input  logic      clk,
    input  logic      cs_n,
    input  logic      ss_n,
    input  logic      sck,
    spi_events_if.src ev
);

    // Synchronizer chains, bit 0 samples the pin
    logic [`IMU_SYNC_STAGES-1:0] ss_sync;
    logic [`IMU_SYNC_STAGES-1:0] sck_sync;

    // Outputs of the chains
    logic ss_s;
    logic sck_s;

    // Previous synchronized levels for edge detection
    logic ss_q;
    logic sck_q;

    assign ss_s  = ss_sync[`IMU_SYNC_STAGES-1];
    assign sck_s = sck_sync[`IMU_SYNC_STAGES-1];

    // --------------------------------------------------
    // Synchronizers and edge register
    // --------------------------------------------------

    // A pin change reaches the strobes after the chain plus one more flop,
    // which is 3 clk cycles with the default depth
    always_ff @(posedge clk or posedge cs_n) begin
        if (cs_n) begin
            // Idle bus: ss_n high and sck low in mode 0
            ss_sync     <= '1;
            sck_sync    <= '0;
            ss_q        <= 1'b1;
            sck_q       <= 1'b0;
            ev.ss_fall  <= 1'b0;
            ev.ss_rise  <= 1'b0;
            ev.sck_rise <= 1'b0;
            ev.sck_fall <= 1'b0;
        end else begin
            ss_sync  <= {ss_sync[`IMU_SYNC_STAGES-2:0], ss_n};
            sck_sync <= {sck_sync[`IMU_SYNC_STAGES-2:0], sck};
            ss_q     <= ss_s;
            sck_q    <= sck_s;

            ev.ss_fall <= ss_q & ~ss_s;
            ev.ss_rise <= ~ss_q & ss_s;

            // Clock edges outside a transaction are noise for this slave
            ev.sck_rise <= ~sck_q & sck_s & ~ss_s;
            ev.sck_fall <= sck_q & ~sck_s & ~ss_s;
        end
    end

    // Selected changes in the same cycle as the slave select strobes
    assign ev.selected = ~ss_q;

endmodule

// ==== hdl/sensor_capture.sv ====
`timescale 1ns/10ps
`include "imu_spi_defines.svh"

module sensor_capture (
    input  logic                 clk,
    input  logic                 cs_n,
    input  logic                 initialized,
    input  logic                 error,
    input  logic                 quat_valid,
    input  imu_spi_pkg::sample_t quat_w,
    input  imu_spi_pkg::sample_t quat_x,
    input  imu_spi_pkg::sample_t quat_y,
    input  imu_spi_pkg::sample_t quat_z,
    input  logic                 gyro_valid,
    input  imu_spi_pkg::sample_t gyro_x,
    input  imu_spi_pkg::sample_t gyro_y,
    input  imu_spi_pkg::sample_t gyro_z,
    spi_events_if.dst            ev,
    sensor_snap_if.src           snap
);
    import imu_spi_pkg::*;

    // Registered copies of the sensor words
    sample_t quat_w_q;
    sample_t quat_x_q;
    sample_t quat_y_q;
    sample_t quat_z_q;
    sample_t gyro_x_q;
    sample_t gyro_y_q;
    sample_t gyro_z_q;

    // Status bits gathered at their flags byte positions
    flags_t status_raw;
    flags_t [`IMU_SYNC_STAGES-1:0] status_sync;
    flags_t status_s;

    // Valid pulses held until the end of the next transaction
    logic quat_latch;
    logic gyro_latch;

    // Flags value the snapshot loads while deselected
    flags_t flags_next;

    // --------------------------------------------------
    // Input registers
    // --------------------------------------------------

    // Data words only matter once a valid latch has picked them up
    always_ff @(posedge clk) begin
        quat_w_q <= quat_w;
        quat_x_q <= quat_x;
        quat_y_q <= quat_y;
        quat_z_q <= quat_z;
        gyro_x_q <= gyro_x;
        gyro_y_q <= gyro_y;
        gyro_z_q <= gyro_z;
    end

    always_comb begin
        status_raw                 = '0;
        status_raw[`IMU_FLAG_QUAT] = quat_valid;
        status_raw[`IMU_FLAG_GYRO] = gyro_valid;
        status_raw[`IMU_FLAG_INIT] = initialized;
        status_raw[`IMU_FLAG_ERR]  = error;
    end

    assign status_s = status_sync[`IMU_SYNC_STAGES-1];

    // --------------------------------------------------
    // Status synchronizers and valid latches
    // --------------------------------------------------

    // A valid pulse is latched 3 cycles after it arrives
    always_ff @(posedge clk or posedge cs_n) begin
        if (cs_n) begin
            status_sync <= '0;
            quat_latch  <= 1'b0;
            gyro_latch  <= 1'b0;
        end else begin
            status_sync <= {status_sync[`IMU_SYNC_STAGES-2:0], status_raw};
            // The end of a transaction consumes whatever the snapshot carried
            if (ev.ss_rise) begin
                quat_latch <= 1'b0;
                gyro_latch <= 1'b0;
            end else if (!ev.selected) begin
                if (status_s[`IMU_FLAG_QUAT]) begin
                    quat_latch <= 1'b1;
                end
                if (status_s[`IMU_FLAG_GYRO]) begin
                    gyro_latch <= 1'b1;
                end
            end
        end
    end

    // Status bits pass straight through, valid bits come from the latches
    always_comb begin
        flags_next                 = status_s;
        flags_next[`IMU_FLAG_QUAT] = quat_latch;
        flags_next[`IMU_FLAG_GYRO] = gyro_latch;
    end

    // --------------------------------------------------
    // Snapshot bank
    // --------------------------------------------------

    // Follows the inputs while deselected and holds while the master reads
    always_ff @(posedge clk or posedge cs_n) begin
        if (cs_n) begin
            snap.quat_w <= '0;
            snap.quat_x <= '0;
            snap.quat_y <= '0;
            snap.quat_z <= '0;
            snap.gyro_x <= '0;
            snap.gyro_y <= '0;
            snap.gyro_z <= '0;
            snap.flags  <= '0;
        end else if (!ev.selected) begin
            snap.flags <= flags_next;
            // Old data stays in place until a new valid sample shows up
            if (quat_latch) begin
                snap.quat_w <= quat_w_q;
                snap.quat_x <= quat_x_q;
                snap.quat_y <= quat_y_q;
                snap.quat_z <= quat_z_q;
            end
            if (gyro_latch) begin
                snap.gyro_x <= gyro_x_q;
                snap.gyro_y <= gyro_y_q;
                snap.gyro_z <= gyro_z_q;
            end
        end
    end

endmodule

// ==== hdl/packet_builder.sv ====
`timescale 1ns/10ps
`include "imu_spi_defines.svh"

module packet_builder (
    sensor_snap_if.dst               snap,
    input  imu_spi_pkg::byte_idx_t   byte_idx,
    output imu_spi_pkg::byte_t       tx_byte
);
    import imu_spi_pkg::*;

    // Words go out high byte first
    function automatic byte_t hi_byte(input sample_t s);
        return s[15:8];
    endfunction

    function automatic byte_t lo_byte(input sample_t s);
        return s[7:0];
    endfunction

    // --------------------------------------------------
    // Packet layout
    // --------------------------------------------------

    // Pure decode of the index, the snapshot is stable while selected
    always_comb begin
        case (byte_idx)
            5'd0:    tx_byte = `IMU_HEADER_BYTE;
            // Quaternion w, x, y, z
            5'd1:    tx_byte = hi_byte(snap.quat_w);
            5'd2:    tx_byte = lo_byte(snap.quat_w);
            5'd3:    tx_byte = hi_byte(snap.quat_x);
            5'd4:    tx_byte = lo_byte(snap.quat_x);
            5'd5:    tx_byte = hi_byte(snap.quat_y);
            5'd6:    tx_byte = lo_byte(snap.quat_y);
            5'd7:    tx_byte = hi_byte(snap.quat_z);
            5'd8:    tx_byte = lo_byte(snap.quat_z);
            // Gyroscope x, y, z
            5'd9:    tx_byte = hi_byte(snap.gyro_x);
            5'd10:   tx_byte = lo_byte(snap.gyro_x);
            5'd11:   tx_byte = hi_byte(snap.gyro_y);
            5'd12:   tx_byte = lo_byte(snap.gyro_y);
            5'd13:   tx_byte = hi_byte(snap.gyro_z);
            5'd14:   tx_byte = lo_byte(snap.gyro_z);
            // Flags in the low nibble, upper bits reserved as zero
            5'd15:   tx_byte = {4'h0, snap.flags};
            // Anything the master clocks past the packet reads as zero
            default: tx_byte = '0;
        endcase
    end

endmodule

// ==== hdl/packet_shifter.sv ====
`timescale 1ns/10ps
`include "imu_spi_defines.svh"

module packet_shifter (
    input  logic                    clk,
    input  logic                    cs_n,
    spi_events_if.dst               ev,
    input  imu_spi_pkg::byte_t      tx_byte,
    output imu_spi_pkg::byte_idx_t  byte_idx,
    output logic                    sdo,
    output logic                    sdo_oe
);
    import imu_spi_pkg::*;

    shift_state_t state;

    // Bits of the current byte already shifted out
    bit_idx_t bit_cnt;

    // MSB is on the wire
    byte_t shreg;

    // --------------------------------------------------
    // Mode 0 shifter FSM
    // --------------------------------------------------

    // byte_idx always points at the byte that the next load takes
    // from the builder, so the header comes from index 0
    always_ff @(posedge clk or posedge cs_n) begin
        if (cs_n) begin
            state    <= st_idle;
            bit_cnt  <= '0;
            byte_idx <= '0;
            shreg    <= '0;
        end else if (!ev.selected) begin
            // Master let go of ss_n, abort wherever we are
            state    <= st_idle;
            bit_cnt  <= '0;
            byte_idx <= '0;
            shreg    <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (ev.ss_fall) begin
                        shreg    <= tx_byte;
                        byte_idx <= byte_idx + 1'b1;
                        bit_cnt  <= '0;
                        state    <= st_wait_first_rise;
                    end
                end
                // Bit 7 of the header must stay put until the master samples it
                st_wait_first_rise: begin
                    if (ev.sck_rise) begin
                        state <= st_shifting;
                    end
                end
                st_shifting: begin
                    if (ev.sck_fall) begin
                        if (bit_cnt == 3'd7) begin
                            shreg   <= tx_byte;
                            bit_cnt <= '0;
                            // Index past the packet loads zero and parks there
                            if (byte_idx == byte_idx_t'(`IMU_PACKET_BYTES)) begin
                                state <= st_drain;
                            end else begin
                                byte_idx <= byte_idx + 1'b1;
                            end
                        end else begin
                            shreg   <= {shreg[6:0], 1'b0};
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                st_drain: begin
                    // Counters hold, only zeros are left to send
                    if (ev.sck_fall) begin
                        shreg <= {shreg[6:0], 1'b0};
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign sdo = shreg[7];

    // Released as soon as selected drops, one cycle before the FSM sees it
    assign sdo_oe = ev.selected && (state != st_idle);

endmodule

// ==== hdl/imu_spi_top.sv ====
`timescale 1ns/10ps

module imu_spi_top (
    input  logic                 clk,
    input  logic                 cs_n,
    // SPI pins, MISO pad is built outside from sdo and sdo_oe
    input  logic                 ss_n,
    input  logic                 sck,
    output logic                 sdo,
    output logic                 sdo_oe,
    // IMU controller side
    input  logic                 initialized,
    input  logic                 error,
    input  logic                 quat_valid,
    input  imu_spi_pkg::sample_t quat_w,
    input  imu_spi_pkg::sample_t quat_x,
    input  imu_spi_pkg::sample_t quat_y,
    input  imu_spi_pkg::sample_t quat_z,
    input  logic                 gyro_valid,
    input  imu_spi_pkg::sample_t gyro_x,
    input  imu_spi_pkg::sample_t gyro_y,
    input  imu_spi_pkg::sample_t gyro_z
);

    // Pin events shared by capture and shifter
    spi_events_if  ev ();

    // Snapshot from capture to packet builder
    sensor_snap_if snap ();

    // Byte select and byte returned between shifter and builder
    imu_spi_pkg::byte_idx_t byte_idx;
    imu_spi_pkg::byte_t     tx_byte;

    spi_pin_sync i_pin_sync (
        .clk  (clk),
        .cs_n (cs_n),
        .ss_n (ss_n),
        .sck  (sck),
        .ev   (ev.src)
    );

    sensor_capture i_capture (
        .clk         (clk),
        .cs_n        (cs_n),
        .initialized (initialized),
        .error       (error),
        .quat_valid  (quat_valid),
        .quat_w      (quat_w),
        .quat_x      (quat_x),
        .quat_y      (quat_y),
        .quat_z      (quat_z),
        .gyro_valid  (gyro_valid),
        .gyro_x      (gyro_x),
        .gyro_y      (gyro_y),
        .gyro_z      (gyro_z),
        .ev          (ev.dst),
        .snap        (snap.src)
    );

    packet_builder i_builder (
        .snap     (snap.dst),
        .byte_idx (byte_idx),
        .tx_byte  (tx_byte)
    );

    packet_shifter i_shifter (
        .clk      (clk),
        .cs_n     (cs_n),
        .ev       (ev.dst),
        .tx_byte  (tx_byte),
        .byte_idx (byte_idx),
        .sdo      (sdo),
        .sdo_oe   (sdo_oe)
    );

endmodule

// ==== bench/imu_spi_tb.sv ====
`timescale 1ns/10ps

module imu_spi_tb;
    import imu_spi_pkg::*;

    // Trace file with the stimulus and the expected bytes of each transaction
    localparam string TRACE_FILE = "bench/imu_spi_trace.txt";

    logic    clk;
    logic    cs_n;
    logic    ss_n;
    logic    sck;
    logic    sdo;
    logic    sdo_oe;
    logic    initialized;
    logic    error;
    logic    quat_valid;
    logic    gyro_valid;
    sample_t quat_w;
    sample_t quat_x;
    sample_t quat_y;
    sample_t quat_z;
    sample_t gyro_x;
    sample_t gyro_y;
    sample_t gyro_z;

    // Fields of the current trace line
    int           mode;
    int           line_qv;
    int           line_gv;
    int           line_init;
    int           line_err;
    sample_t      line_q [4];
    sample_t      line_g [3];
    logic [135:0] exp_pkt;

    // Half period of sck in clk cycles that each transaction draws anew
    int half;
    int n_trans;

    initial clk = 1'b0;
    always #4 clk = ~clk;

    imu_spi_top i_dut (
        .clk         (clk),
        .cs_n        (cs_n),
        .ss_n        (ss_n),
        .sck         (sck),
        .sdo         (sdo),
        .sdo_oe      (sdo_oe),
        .initialized (initialized),
        .error       (error),
        .quat_valid  (quat_valid),
        .quat_w      (quat_w),
        .quat_x      (quat_x),
        .quat_y      (quat_y),
        .quat_z      (quat_z),
        .gyro_valid  (gyro_valid),
        .gyro_x      (gyro_x),
        .gyro_y      (gyro_y),
        .gyro_z      (gyro_z)
    );

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------

    task automatic check_value(input logic [7:0] got, input logic [7:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("error at %0t ns: %s read %h, expected %h", $time, what, got, expected);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    // Drives the line's sensor values, or their complement for the mid-transfer disturbance
    task automatic set_inputs(input logic inv);
        logic [15:0] mask;
        mask = {16{inv}};
        @(posedge clk);
        quat_w      <= line_q[0] ^ mask;
        quat_x      <= line_q[1] ^ mask;
        quat_y      <= line_q[2] ^ mask;
        quat_z      <= line_q[3] ^ mask;
        gyro_x      <= line_g[0] ^ mask;
        gyro_y      <= line_g[1] ^ mask;
        gyro_z      <= line_g[2] ^ mask;
        initialized <= line_init[0] ^ inv;
        error       <= line_err[0] ^ inv;
    endtask

    // One clk cycle valid strobe as the IMU controller issues it
    task automatic pulse_valid(input logic pq, input logic pg);
        @(posedge clk);
        quat_valid <= pq;
        gyro_valid <= pg;
        @(posedge clk);
        quat_valid <= 1'b0;
        gyro_valid <= 1'b0;
    endtask

    task automatic wait_for_oe(input int limit);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (sdo_oe !== 1'b1) begin
            if (cycles >= limit) begin
                $display("timeout: sdo_oe did not rise within %0d cycles of ss_n falling", limit);
                $display("Checks failed");
                $fatal(1);
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    // Mode 0 master that samples sdo MSB first just before each sck rise
    task automatic shift_byte(output logic [7:0] value);
        value = '0;
        for (int i = 7; i >= 0; i--) begin
            repeat (half - 1) @(posedge clk);
            @(negedge clk);
            value[i] = sdo;
            check_value(8'(sdo_oe), 8'h01, "sdo_oe during a transfer");
            @(posedge clk);
            sck <= 1'b1;
            repeat (half) @(posedge clk);
            sck <= 1'b0;
        end
    endtask

    // --------------------------------------------------
    // One SPI transaction per trace line
    // --------------------------------------------------

    task automatic run_transaction(input int idx);
        logic [7:0] got;
        string      what;
        set_inputs(1'b0);
        if (mode != 1) begin
            pulse_valid(line_qv[0], line_gv[0]);
        end
        // Far longer than the 4 cycles the capture path needs
        repeat (8) @(posedge clk);
        half = 5 + int'($urandom % 4);
        ss_n <= 1'b0;
        wait_for_oe(10);
        repeat (2) @(posedge clk);
        for (int b = 0; b < 17; b++) begin
            // Disturb the inputs in the middle of the packet and keep them disturbed
            // until the flags byte has gone out
            if (mode == 2 && b == 5) begin
                set_inputs(1'b1);
                pulse_valid(1'b1, 1'b1);
            end
            if (mode == 2 && b == 16) begin
                set_inputs(1'b0);
            end
            shift_byte(got);
            what = $sformatf("transaction %0d byte %0d", idx, b);
            check_value(got, exp_pkt[135 - 8*b -: 8], what);
        end
        repeat (5) @(posedge clk);
        ss_n <= 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_value(8'(sdo_oe), 8'h00, "sdo_oe with ss_n high for 3 cycles");
        repeat (6) @(posedge clk);
    endtask

    task automatic read_trace(input int fd);
        int    n;
        string line;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // Column notes and blank lines carry no transaction
            if (n > 1 && line.substr(0, 0) != "#") begin
                n = $sscanf(line, "%d %d %d %d %d %h %h %h %h %h %h %h %h",
                            mode, line_qv, line_gv, line_init, line_err,
                            line_q[0], line_q[1], line_q[2], line_q[3],
                            line_g[0], line_g[1], line_g[2], exp_pkt);
                if (n != 13) begin
                    $display("trace line %0d could not be parsed: %s", n_trans + 1, line);
                    $display("Checks failed");
                    $fatal(1);
                end else begin
                    run_transaction(n_trans);
                    n_trans++;
                end
            end
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------

    initial begin
        int fd;
        void'($urandom(32'hb28087cd));
        cs_n        <= 1'b1;
        ss_n        <= 1'b1;
        sck         <= 1'b0;
        initialized <= 1'b0;
        error       <= 1'b0;
        quat_valid  <= 1'b0;
        gyro_valid  <= 1'b0;
        quat_w      <= '0;
        quat_x      <= '0;
        quat_y      <= '0;
        quat_z      <= '0;
        gyro_x      <= '0;
        gyro_y      <= '0;
        gyro_z      <= '0;
        n_trans = 0;

        // Pin outputs are quiet while reset is held
        repeat (7) @(posedge clk);
        @(negedge clk);
        check_value(8'(sdo), 8'h00, "sdo in reset");
        check_value(8'(sdo_oe), 8'h00, "sdo_oe in reset");
        @(posedge clk);
        cs_n <= 1'b0;
        repeat (4) @(posedge clk);

        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("the trace file %s could not be opened", TRACE_FILE);
            $display("Checks failed");
            $fatal(1);
        end else begin
            read_trace(fd);
            $fclose(fd);
            if (n_trans == 0) begin
                $display("the trace file holds no transaction");
                $display("Checks failed");
                $fatal(1);
            end else begin
                $display("All checks passed");
                $finish;
            end
        end
    end

endmodule

// ==== imu_spi.f ====
+incdir+include
hdl/imu_spi_pkg.sv
hdl/spi_events_if.sv
hdl/sensor_snap_if.sv
hdl/spi_pin_sync.sv
hdl/sensor_capture.sv
hdl/packet_builder.sv
hdl/packet_shifter.sv
hdl/imu_spi_top.sv
bench/imu_spi_tb.sv

// ==== Makefile ====
# Verilator build of the IMU SPI slave testbench
# A failing run ends in $fatal, so the simulator exit status is the verdict

.PHONY: compile run clean

compile:
	verilator --binary --timing --timescale 1ns/10ps -f imu_spi.f \
		--top-module imu_spi_tb -Mdir obj_dir -o imu_spi_sim

run: compile
	./obj_dir/imu_spi_sim

clean:
	rm -rf obj_dir

// ==== bench/imu_spi_trace.txt ====
# mode qv gv init err quat_w quat_x quat_y quat_z gyro_x gyro_y gyro_z packet
# mode 0 pulses the valids before ss_n falls, 1 sends no pulse, 2 also changes inputs mid-transfer
# packet holds the 17 expected bytes as one hex word, byte 0 first
1 0 0 1 0 1111 2222 3333 4444 5555 6666 7777 AA00000000000000000000000000000400
0 1 1 1 0 1234 8001 7FFF FEDC 0102 A5A5 C3C4 AA123480017FFFFEDC0102A5A5C3C40700
1 0 0 1 0 DEAD BEEF CAFE F00D 1357 2468 9ABC AA123480017FFFFEDC0102A5A5C3C40400
0 1 0 1 1 0F0F F0F0 0001 FFFF AAAA BBBB CCCC AA0F0FF0F00001FFFF0102A5A5C3C40D00
0 0 1 0 1 1111 1111 1111 1111 8000 0001 7FFE AA0F0FF0F00001FFFF800000017FFE0A00
2 1 1 1 0 4321 8765 0BAD 1F2E 3C3C 5A5A 6969 AA432187650BAD1F2E3C3C5A5A69690700
1 0 0 1 0 0000 0000 0000 0000 FFFF FFFF FFFF AA432187650BAD1F2E3C3C5A5A69690400
2 0 0 0 0 ABCD 1234 5678 9ABC DEF0 1111 2222 AA432187650BAD1F2E3C3C5A5A69690000
0 1 1 1 1 7FFF 8000 FFFF 0000 0001 FFFE 8001 AA7FFF8000FFFF00000001FFFE80010F00
1 0 0 0 0 2222 3333 4444 5555 6666 7777 8888 AA7FFF8000FFFF00000001FFFE80010000
